/* verilog/instrPkg.sv */
// Instruction codes and classes seen by the memory and writeback stages.
// Every stage imports this package to decode the operation it carries.

package instrPkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // instruction codes
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int INSTR_W = 4;

    localparam logic [INSTR_W-1:0] LW  = 4'd0;
    localparam logic [INSTR_W-1:0] LH  = 4'd1;
    localparam logic [INSTR_W-1:0] LHU = 4'd2;
    localparam logic [INSTR_W-1:0] LB  = 4'd3;
    localparam logic [INSTR_W-1:0] LBU = 4'd4;
    localparam logic [INSTR_W-1:0] SW  = 4'd5;
    localparam logic [INSTR_W-1:0] SH  = 4'd6;
    localparam logic [INSTR_W-1:0] SB  = 4'd7;
    localparam logic [INSTR_W-1:0] ALU = 4'd8;  // any register-writing arithmetic op
    localparam logic [INSTR_W-1:0] NOP = 4'd9;

    // ~~~~~~~~~~~~~~~~~~~~
    // functional classes
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int IFUNC_W = 2;

    localparam logic [IFUNC_W-1:0] I_NONE  = 2'd0;  // bubble
    localparam logic [IFUNC_W-1:0] I_ALU   = 2'd1;
    localparam logic [IFUNC_W-1:0] I_MEM_R = 2'd2;  // load
    localparam logic [IFUNC_W-1:0] I_MEM_W = 2'd3;  // store

    // register index width
    localparam int REG_ADDR_W = 5;

endpackage

/* verilog/memPkg.sv */
// Data word layout and access-unit decoding for loads and stores.
// The memory stage and the load extender both decode units through unitOf.

package memPkg;

    import instrPkg::*;

    localparam int WORD_W = 32;

    // access unit of a load or store
    localparam int UNIT_W = 2;
    localparam logic [UNIT_W-1:0] UNIT_WORD = 2'd0;
    localparam logic [UNIT_W-1:0] UNIT_HALF = 2'd1;
    localparam logic [UNIT_W-1:0] UNIT_BYTE = 2'd2;

    // one memory word, seen whole, as halfwords or as byte lanes
    typedef union packed {
        logic [WORD_W-1:0] word;
        logic [1:0][15:0]  half;  // half[1] is the upper halfword
        logic [3:0][7:0]   lane;  // lane[0] is the lowest byte
    } memWord_u;

    function automatic logic [UNIT_W-1:0] unitOf(input logic [INSTR_W-1:0] code);
        case (code)
            LW, SW:       unitOf = UNIT_WORD;
            LH, LHU, SH:  unitOf = UNIT_HALF;
            LB, LBU, SB:  unitOf = UNIT_BYTE;
            default:      unitOf = UNIT_WORD;  // non-memory ops
        endcase
    endfunction

endpackage

/* verilog/dataMemory.sv */
// Word-organized data RAM with one write enable per byte lane.
// Writes land at the clock edge; the addressed word is read combinationally.
// Instantiated by the memory stage, which supplies aligned lanes.

`timescale 1ns/1ps

module dataMemory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         writeEnable,
    input  logic [3:0]                   byteEnable,
    input  logic [$clog2(MEM_WORDS)-1:0] wordAddr,
    input  logic [memPkg::WORD_W-1:0]    writeData,
    output logic [memPkg::WORD_W-1:0]    readData
);

    import memPkg::*;

    logic [WORD_W-1:0] mem [MEM_WORDS];  // contents survive reset

    // ~~~~~~~~~~~~~~~~~~~~
    // lane writes
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (writeEnable)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (byteEnable[b])
                begin
                    mem[wordAddr][b*8 +: 8] <= writeData[b*8 +: 8];
                end
            end
        end
    end

    // read sees old data during a write cycle
    assign readData = mem[wordAddr];

    // a strobe with no lanes means the store unit was not decoded
    noEmptyWrite: assert property (
        @(posedge clk) writeEnable |-> (byteEnable != 4'b0000)
    ) else $error("data memory write strobe with no byte lanes");

endmodule

/* verilog/stageMem.sv */
// Memory-access stage. Decodes the access unit, forms byte enables from
// the address offset, replicates store data into lanes and drives the RAM.
// The read word and low address bits go on to the writeback stage.

`timescale 1ns/1ps

module stageMem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [instrPkg::INSTR_W-1:0]  instr,
    input  logic [instrPkg::IFUNC_W-1:0]  ifunc,
    input  logic [memPkg::WORD_W-1:0]     aluResult,  // effective address
    input  logic [memPkg::WORD_W-1:0]     storeData,
    output logic [memPkg::WORD_W-1:0]     memWord,
    output logic [1:0]                    offset
);

    import instrPkg::*;
    import memPkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic [UNIT_W-1:0] unit;
    logic [ADDR_W-1:0] wordAddr;
    logic [3:0]        byteEnable;
    memWord_u          storeLanes;
    logic              memWrite;
    logic              isMemAccess;

    assign unit        = unitOf(instr);
    assign wordAddr    = aluResult[ADDR_W+1:2];  // wraps at memory size
    assign memWrite    = (ifunc == I_MEM_W);     // level for this cycle only
    assign isMemAccess = (ifunc == I_MEM_R) || (ifunc == I_MEM_W);

    // ~~~~~~~~~~~~~~~~~~~~
    // lane selection
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        case (unit)
            UNIT_WORD: byteEnable = 4'b1111;
            UNIT_HALF: byteEnable = aluResult[1] ? 4'b1100 : 4'b0011;
            UNIT_BYTE: byteEnable = 4'b0001 << aluResult[1:0];
            default:   byteEnable = 4'b0000;
        endcase
    end

    // same data in every lane, the enables pick the one that lands
    always_comb
    begin
        storeLanes.word = storeData;
        case (unit)
            UNIT_HALF: storeLanes.half = {2{storeData[15:0]}};
            UNIT_BYTE: storeLanes.lane = {4{storeData[7:0]}};
            default:   storeLanes.word = storeData;
        endcase
    end

    dataMemory #(
        .MEM_WORDS(MEM_WORDS)
    ) dataMemory_inst (
        .clk        (clk),
        .writeEnable(memWrite),
        .byteEnable (byteEnable),
        .wordAddr   (wordAddr),
        .writeData  (storeLanes.word),
        .readData   (memWord)
    );

    assign offset = aluResult[1:0];

    // misaligned accesses are outside this design
    alignHalf: assert property (
        @(posedge clk) disable iff (reset)
        (isMemAccess && unit == UNIT_HALF) |-> !aluResult[0]
    ) else $error("halfword access at odd address %h", aluResult);

    alignWord: assert property (
        @(posedge clk) disable iff (reset)
        (isMemAccess && unit == UNIT_WORD) |-> (aluResult[1:0] == 2'b00)
    ) else $error("word access not word-aligned at %h", aluResult);

endmodule

/* verilog/loadExtend.sv */
// Load data extension for the writeback stage. Picks the byte or halfword
// named by the offset out of the loaded word and sign- or zero-extends it.
// Word loads pass through unchanged.

`timescale 1ns/1ps

module loadExtend (
    input  logic [memPkg::WORD_W-1:0]    memWord,
    input  logic [1:0]                   offset,
    input  logic [instrPkg::INSTR_W-1:0] instr,
    output logic [memPkg::WORD_W-1:0]    extWord
);

    import instrPkg::*;
    import memPkg::*;

    memWord_u          loaded;
    logic [UNIT_W-1:0] unit;
    logic [15:0]       halfSel;
    logic [7:0]        byteSel;
    logic              signExt;

    assign loaded  = memWord;
    assign unit    = unitOf(instr);
    assign signExt = (instr == LH) || (instr == LB);  // LHU and LBU zero-extend

    // ~~~~~~~~~~~~~~~~~~~~
    // part selection
    // ~~~~~~~~~~~~~~~~~~~~
    assign halfSel = loaded.half[offset[1]];  // bit 0 is zero for halfwords
    assign byteSel = loaded.lane[offset];

    // ~~~~~~~~~~~~~~~~~~~~
    // extension
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        case (unit)
            UNIT_HALF:
            begin
                extWord = {{16{signExt & halfSel[15]}}, halfSel};
            end
            UNIT_BYTE:
            begin
                extWord = {{24{signExt & byteSel[7]}}, byteSel};
            end
            default:
            begin
                extWord = loaded.word;  // LW
            end
        endcase
    end

endmodule

/* verilog/stageWb.sv */
// Writeback stage. Holds the MEM/WB pipeline register, chooses between
// the extended load word and the ALU result, and drives the register
// file write port one cycle after capture.

`timescale 1ns/1ps

module stageWb (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [instrPkg::INSTR_W-1:0]    instr,
    input  logic [instrPkg::IFUNC_W-1:0]    ifunc,
    input  logic [memPkg::WORD_W-1:0]       memWord,
    input  logic [1:0]                      offset,
    input  logic [memPkg::WORD_W-1:0]       aluResult,
    input  logic [instrPkg::REG_ADDR_W-1:0] destReg,
    input  logic                            writeDisable,
    output logic [instrPkg::REG_ADDR_W-1:0] regWriteAddr,
    output logic [memPkg::WORD_W-1:0]       regWriteData,
    output logic                            regWriteEnable
);

    import instrPkg::*;
    import memPkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // MEM/WB register
    // ~~~~~~~~~~~~~~~~~~~~
    logic [IFUNC_W-1:0]    ifuncWb;
    logic                  writeDisableWb;
    logic [INSTR_W-1:0]    instrWb;
    logic [1:0]            offsetWb;
    logic [WORD_W-1:0]     memWordWb;
    logic [WORD_W-1:0]     aluResultWb;
    logic [REG_ADDR_W-1:0] destRegWb;
    logic [WORD_W-1:0]     extWord;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ifuncWb        <= I_NONE;  // bubble
            writeDisableWb <= 1'b1;
        end
        else
        begin
            ifuncWb        <= ifunc;
            writeDisableWb <= writeDisable;
        end
    end

    // payload, only meaningful alongside ifuncWb
    always_ff @(posedge clk)
    begin
        instrWb     <= instr;
        offsetWb    <= offset;
        memWordWb   <= memWord;
        aluResultWb <= aluResult;
        destRegWb   <= destReg;
    end

    loadExtend loadExtend_inst (
        .memWord(memWordWb),
        .offset (offsetWb),
        .instr  (instrWb),
        .extWord(extWord)
    );

    assign regWriteAddr   = destRegWb;
    assign regWriteData   = (ifuncWb == I_MEM_R) ? extWord : aluResultWb;
    assign regWriteEnable = ((ifuncWb == I_ALU) || (ifuncWb == I_MEM_R))
                            && !writeDisableWb
                            && (destRegWb != '0);  // r0 never written

endmodule

/* verilog/regFile.sv */
// General register file with one write port and two read ports.
// Writes happen at the clock edge; reads are combinational and do not
// forward a write from the same cycle. Register 0 always reads zero.

`timescale 1ns/1ps

module regFile #(
    parameter int NUM_REGS = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            writeEnable,
    input  logic [instrPkg::REG_ADDR_W-1:0] writeAddr,
    input  logic [memPkg::WORD_W-1:0]       writeData,
    input  logic [instrPkg::REG_ADDR_W-1:0] readAddrA,
    input  logic [instrPkg::REG_ADDR_W-1:0] readAddrB,
    output logic [memPkg::WORD_W-1:0]       readDataA,
    output logic [memPkg::WORD_W-1:0]       readDataB
);

    import memPkg::*;

    logic [WORD_W-1:0] regs [NUM_REGS];

    // ~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int r = 0; r < NUM_REGS; r++)
            begin
                regs[r] <= '0;
            end
        end
        else if (writeEnable)
        begin
            regs[writeAddr] <= writeData;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read ports
    // ~~~~~~~~~~~~~~~~~~~~
    // out-of-range indices read as zero too
    assign readDataA = ((readAddrA == '0) || (int'(readAddrA) >= NUM_REGS)) ?
                       '0 : regs[readAddrA];
    assign readDataB = ((readAddrB == '0) || (int'(readAddrB) >= NUM_REGS)) ?
                       '0 : regs[readAddrB];

    // the writeback stage must never aim past the array
    writeInRange: assert property (
        @(posedge clk) disable iff (reset)
        writeEnable |-> (int'(writeAddr) < NUM_REGS)
    ) else $error("register write to index %0d beyond %0d registers",
                  writeAddr, NUM_REGS);

endmodule

/* verilog/memWbTop.sv */
// Back end of the integer pipeline: memory stage, writeback stage and
// register file. Takes the execute-stage outputs as loose inputs each
// cycle and exposes two register read ports for observation.

`timescale 1ns/1ps

module memWbTop #(
    parameter int MEM_WORDS = 256,
    parameter int NUM_REGS  = 32
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [instrPkg::INSTR_W-1:0]    instr,
    input  logic [instrPkg::IFUNC_W-1:0]    ifunc,
    input  logic [memPkg::WORD_W-1:0]       aluResult,  // address or data
    input  logic [memPkg::WORD_W-1:0]       storeData,
    input  logic [instrPkg::REG_ADDR_W-1:0] destReg,
    input  logic                            writeDisable,
    input  logic [instrPkg::REG_ADDR_W-1:0] readAddrA,
    input  logic [instrPkg::REG_ADDR_W-1:0] readAddrB,
    output logic [memPkg::WORD_W-1:0]       readDataA,
    output logic [memPkg::WORD_W-1:0]       readDataB
);

    import instrPkg::*;
    import memPkg::*;

    // MEM to WB
    logic [WORD_W-1:0]     memWord;
    logic [1:0]            offset;

    // WB to register file
    logic [REG_ADDR_W-1:0] regWriteAddr;
    logic [WORD_W-1:0]     regWriteData;
    logic                  regWriteEnable;

    stageMem #(
        .MEM_WORDS(MEM_WORDS)
    ) stageMem_inst (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .ifunc    (ifunc),
        .aluResult(aluResult),
        .storeData(storeData),
        .memWord  (memWord),
        .offset   (offset)
    );

    stageWb stageWb_inst (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .ifunc         (ifunc),
        .memWord       (memWord),
        .offset        (offset),
        .aluResult     (aluResult),
        .destReg       (destReg),
        .writeDisable  (writeDisable),
        .regWriteAddr  (regWriteAddr),
        .regWriteData  (regWriteData),
        .regWriteEnable(regWriteEnable)
    );

    regFile #(
        .NUM_REGS(NUM_REGS)
    ) regFile_inst (
        .clk        (clk),
        .reset      (reset),
        .writeEnable(regWriteEnable),
        .writeAddr  (regWriteAddr),
        .writeData  (regWriteData),
        .readAddrA  (readAddrA),
        .readAddrB  (readAddrB),
        .readDataA  (readDataA),
        .readDataB  (readDataB)
    );

endmodule

/* dv/memWbTb.sv */
// Testbench for the memory/writeback back end. Issues operations the way
// the execute stage would, keeps a model data memory and register file,
// and reads registers back through both read ports to compare.
// Ends with one line per test, the counts and the final verdict.

`timescale 1ns/1ps

module memWbTb;

    import instrPkg::*;
    import memPkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int NUM_REGS     = 32;
    localparam int ADDR_W       = $clog2(MEM_WORDS);
    localparam int RANDOM_OPS   = 300;
    localparam int DIRECTED_OPS = 500;  // directed tests and register sweeps
    localparam int TIMEOUT_NS   = (RANDOM_OPS + DIRECTED_OPS) * 20 + 2000;

    logic                  clk;
    logic                  reset;
    logic [INSTR_W-1:0]    instr;
    logic [IFUNC_W-1:0]    ifunc;
    logic [WORD_W-1:0]     aluResult;
    logic [WORD_W-1:0]     storeData;
    logic [REG_ADDR_W-1:0] destReg;
    logic                  writeDisable;
    logic [REG_ADDR_W-1:0] readAddrA;
    logic [REG_ADDR_W-1:0] readAddrB;
    logic [WORD_W-1:0]     readDataA;
    logic [WORD_W-1:0]     readDataB;

    logic [WORD_W-1:0]  modelMem [MEM_WORDS];
    logic [WORD_W-1:0]  modelRegs [NUM_REGS];
    logic [WORD_W-1:0]  extWords [3] = '{32'h8F7F_80FF, 32'hF0E1_D2C3, 32'hC0FF_EE80};
    logic [INSTR_W-1:0] loadCodes [4] = '{LB, LBU, LH, LHU};
    logic [INSTR_W-1:0] mixCodes [10] = '{SW, SH, SB, LW, LH, LHU, LB, LBU, ALU, NOP};
    integer             seed = 69;
    int                 testErrors = 0;
    int                 passCount = 0;
    int                 failCount = 0;

    memWbTop #(
        .MEM_WORDS(MEM_WORDS),
        .NUM_REGS (NUM_REGS)
    ) memWbTop_inst (
        .clk(clk), .reset(reset), .instr(instr), .ifunc(ifunc),
        .aluResult(aluResult), .storeData(storeData), .destReg(destReg),
        .writeDisable(writeDisable), .readAddrA(readAddrA), .readAddrB(readAddrB),
        .readDataA(readDataA), .readDataB(readDataB)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [WORD_W-1:0] mergeStore(input logic [WORD_W-1:0] old,
        input logic [INSTR_W-1:0] code, input logic [1:0] off, input logic [WORD_W-1:0] data);
        logic [WORD_W-1:0] merged;
        merged = old;
        case (code)
            SH:      merged[16*int'(off[1]) +: 16] = data[15:0];
            SB:      merged[8*int'(off) +: 8] = data[7:0];
            default: merged = data;
        endcase
        return merged;
    endfunction

    // value written back for an op, given the word at its address
    function automatic logic [WORD_W-1:0] expectedResult(input logic [INSTR_W-1:0] code,
        input logic [IFUNC_W-1:0] cls, input logic [WORD_W-1:0] alu,
        input logic [WORD_W-1:0] word);
        logic [15:0] half;
        logic [7:0]  byteVal;
        half    = word[16*int'(alu[1]) +: 16];
        byteVal = word[8*int'(alu[1:0]) +: 8];
        if (cls != I_MEM_R)
            return alu;
        case (code)
            LH:      return {{16{half[15]}}, half};
            LHU:     return {16'h0000, half};
            LB:      return {{24{byteVal[7]}}, byteVal};
            LBU:     return {24'h00_0000, byteVal};
            default: return word;
        endcase
    endfunction

    function automatic logic [IFUNC_W-1:0] classOf(input logic [INSTR_W-1:0] code);
        case (code)
            LW, LH, LHU, LB, LBU: return I_MEM_R;
            SW, SH, SB:           return I_MEM_W;
            ALU:                  return I_ALU;
            default:              return I_NONE;
        endcase
    endfunction

    function automatic logic [1:0] alignedOffset(input logic [INSTR_W-1:0] code,
        input logic [WORD_W-1:0] r);
        case (code)
            LB, LBU, SB: return r[1:0];
            LH, LHU, SH: return {r[0], 1'b0};
            default:     return 2'b00;
        endcase
    endfunction

    function automatic logic [REG_ADDR_W-1:0] randNonzeroReg();
        return REG_ADDR_W'(1 + ($unsigned($random(seed)) % 31));
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus and compare
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic issueOp(input logic [INSTR_W-1:0] code, input logic [IFUNC_W-1:0] cls,
        input logic [WORD_W-1:0] alu, input logic [WORD_W-1:0] data,
        input logic [REG_ADDR_W-1:0] dest, input logic wd);
        logic [ADDR_W-1:0] idx;
        logic [WORD_W-1:0] result;
        @(posedge clk);
        instr        <= code;
        ifunc        <= cls;
        aluResult    <= alu;
        storeData    <= data;
        destReg      <= dest;
        writeDisable <= wd;
        idx = alu[ADDR_W+1:2];  // model memory wraps like the RAM
        if (cls == I_MEM_W)
            modelMem[idx] = mergeStore(modelMem[idx], code, alu[1:0], data);
        result = expectedResult(code, cls, alu, modelMem[idx]);
        if ((cls == I_ALU || cls == I_MEM_R) && !wd && dest != '0)
            modelRegs[dest] = result;
    endtask

    task automatic bubble();
        issueOp(NOP, I_NONE, '0, '0, '0, 1'b1);
    endtask

    // two-cycle reset pulse in the middle of a run
    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < NUM_REGS; r++)
            modelRegs[r] = '0;
    endtask

    task automatic compareReg(input logic [REG_ADDR_W-1:0] idx, input logic [WORD_W-1:0] actual);
        if (actual !== modelRegs[idx])
        begin
            $display("[FAIL] %0t ns: r%0d expected %h got %h", $time, idx, modelRegs[idx], actual);
            testErrors++;
        end
    endtask

    // read both ports mid-cycle two edges after the last issue
    task automatic checkPair(input logic [REG_ADDR_W-1:0] a, input logic [REG_ADDR_W-1:0] b);
        bubble();
        @(posedge clk);
        readAddrA <= a;
        readAddrB <= b;
        @(negedge clk);
        compareReg(a, readDataA);
        compareReg(b, readDataB);
    endtask

    // every register passes through port A and port B once
    task automatic checkAll();
        bubble();
        for (int r = 0; r < NUM_REGS; r++)
        begin
            @(posedge clk);
            readAddrA <= REG_ADDR_W'(r);
            readAddrB <= REG_ADDR_W'(NUM_REGS - 1 - r);
            @(negedge clk);
            compareReg(REG_ADDR_W'(r), readDataA);
            compareReg(REG_ADDR_W'(NUM_REGS - 1 - r), readDataB);
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0)
        begin
            $display("test %s: ok", name);
            passCount++;
        end
        else
        begin
            $display("test %s: %0d mismatches", name, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        logic [REG_ADDR_W-1:0] dest;
        logic [WORD_W-1:0]     base;
        logic [WORD_W-1:0]     addr;
        logic [INSTR_W-1:0]    code;
        int                    destCount;
        reset = 1'b1;
        instr = NOP;
        ifunc = I_NONE;
        aluResult = '0;
        storeData = '0;
        destReg = '0;
        writeDisable = 1'b1;
        readAddrA = '0;
        readAddrB = '0;
        destCount = 0;
        for (int r = 0; r < NUM_REGS; r++)
            modelRegs[r] = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        checkAll();
        for (int r = 1; r < NUM_REGS; r++)
            issueOp(ALU, I_ALU, $random(seed) | 1, '0, REG_ADDR_W'(r), 1'b0);  // nonzero
        bubble();
        applyReset();
        checkAll();
        finishTest("reset");

        for (int i = 0; i < 8; i++)
        begin
            dest = randNonzeroReg();
            issueOp(ALU, I_ALU, $random(seed), '0, dest, 1'b0);
            checkPair(dest, dest);
        end
        for (int i = 0; i < 6; i++)
            issueOp(ALU, I_ALU, $random(seed), '0, randNonzeroReg(), 1'b0);  // back to back
        checkAll();
        finishTest("alu writeback");

        for (int w = 0; w < 3; w++)
        begin
            base = 32'((16 + w) * 4);
            issueOp(SW, I_MEM_W, base, $random(seed), '0, 1'b1);
            issueOp(SH, I_MEM_W, base + 32'((w % 2) * 2), $random(seed), '0, 1'b1);
            issueOp(SB, I_MEM_W, base + 32'(w), $random(seed), '0, 1'b1);
            issueOp(SB, I_MEM_W, base + 32'(3 - w), $random(seed), '0, 1'b1);
            issueOp(LW, I_MEM_R, base, '0, REG_ADDR_W'(20 + w), 1'b0);
            checkPair(REG_ADDR_W'(20 + w), REG_ADDR_W'(20 + w));
        end
        finishTest("store merging");

        for (int w = 0; w < 3; w++)
        begin
            base = 32'((32 + w) * 4);
            issueOp(SW, I_MEM_W, base, extWords[w], '0, 1'b1);
            for (int c = 0; c < 4; c++)
            begin
                for (int off = 0; off < 4; off += (c < 2) ? 1 : 2)
                begin
                    dest = REG_ADDR_W'(1 + destCount % 31);
                    destCount++;
                    issueOp(loadCodes[c], I_MEM_R, base + 32'(off), '0, dest, 1'b0);
                    checkPair(dest, dest);
                end
            end
        end
        finishTest("extension");

        for (int i = 1; i < 9; i++)
            issueOp(ALU, I_ALU, $random(seed), '0, REG_ADDR_W'(i), 1'b1);
        issueOp(ALU, I_ALU, 32'hDEAD_BEEF, '0, '0, 1'b0);
        issueOp(LW, I_MEM_R, 32'(16 * 4), '0, '0, 1'b0);
        issueOp(LB, I_MEM_R, 32'(32 * 4 + 1), '0, REG_ADDR_W'(5), 1'b1);
        checkAll();
        finishTest("suppressed writes");

        for (int i = 0; i < 16; i++)
            issueOp(SW, I_MEM_W, 32'((64 + i) * 4), $random(seed), '0, 1'b1);  // loads stay here
        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            code = mixCodes[int'($unsigned($random(seed)) % 10)];
            addr = 32'((64 + int'($unsigned($random(seed)) % 16)) * 4);
            addr[1:0] = alignedOffset(code, $random(seed));
            if (code == ALU)
                addr = $random(seed);
            issueOp(code, classOf(code), addr, $random(seed),
                    REG_ADDR_W'($unsigned($random(seed))), ($random(seed) & 7) == 0);
        end
        checkAll();
        finishTest("random mix");

        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* flist.f */
verilog/instrPkg.sv
verilog/memPkg.sv
verilog/dataMemory.sv
verilog/stageMem.sv
verilog/loadExtend.sv
verilog/stageWb.sv
verilog/regFile.sv
verilog/memWbTop.sv
dv/memWbTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module memWbTb -f flist.f \
    --Mdir obj_dir -o memWbSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/memWbSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
